// ==== Bender.yml ====
package:
  name: rob_subsystem

dependencies: {}

sources:
  # design, in compile order
  - src/robPkg.sv
  - src/reorderBuffer.sv
  - src/regStatusTable.sv
  - src/robSubsystem.sv
  # testbench and bound assertions
  - target: test
    files:
      - tb/reorderBuffer_asserts.sv
      - tb/tbRobSubsystem.sv

// ==== sim.f ====
src/robPkg.sv
src/reorderBuffer.sv
src/regStatusTable.sv
src/robSubsystem.sv
tb/reorderBuffer_asserts.sv
tb/tbRobSubsystem.sv

// ==== src/regStatusTable.sv ====
`timescale 1ns/1ps
// Architectural registers with the ROB tag of each register's newest writer.
// Register 0 is never renamed or written and so always reads 0.
// Lookups of a pending register go through the ROB read ports.
module regStatusTable import robPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   dispatchValid,
    input  opcodeT dispatchOp,
    input  regIdxT dispatchRd,
    input  tagT    allocTag,
    input  regIdxT srcA,
    input  regIdxT srcB,
    input  dataT   queryDataA,
    input  dataT   queryDataB,
    input  logic   queryReadyA,
    input  logic   queryReadyB,
    input  logic   commitValid,
    input  ctrlT   commitCtrl,
    input  regIdxT commitRd,
    input  dataT   commitData,
    input  tagT    commitTag,
    input  logic   flush,
    output tagT    queryTagA,
    output tagT    queryTagB,
    output dataT   srcAValue,
    output dataT   srcBValue,
    output logic   srcAReady,
    output logic   srcBReady,
    output tagT    srcATag,
    output tagT    srcBTag
);

    dataT regValue [numRegs];
    tagT  regTag   [numRegs];  // 0 when the value is architectural

    logic commitWrite;
    logic renameHit;

    assign commitWrite = commitValid && commitCtrl[ctrlRegWrite] && (commitRd != '0);
    assign renameHit   = dispatchValid && writesReg(dispatchOp) && (dispatchRd != '0);

    // pending tag goes straight to the ROB read port
    assign queryTagA = regTag[srcA];
    assign queryTagB = regTag[srcB];
    assign srcATag   = queryTagA;
    assign srcBTag   = queryTagB;

    // no pending writer means the register file holds the value
    assign srcAValue = (queryTagA != '0) ? queryDataA : regValue[srcA];
    assign srcBValue = (queryTagB != '0) ? queryDataB : regValue[srcB];
    assign srcAReady = (queryTagA != '0) ? queryReadyA : 1'b1;
    assign srcBReady = (queryTagB != '0) ? queryReadyB : 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regValue[i] <= '0;
                regTag[i]   <= '0;
            end
        end else begin
            if (commitWrite) begin
                regValue[commitRd] <= commitData;
                // a younger writer keeps its tag
                if (regTag[commitRd] == commitTag)
                    regTag[commitRd] <= '0;
            end
            if (flush) begin
                for (int i = 0; i < numRegs; i++)
                    regTag[i] <= '0;  // all ROB entries are gone
            end else if (renameHit) begin
                regTag[dispatchRd] <= allocTag;  // overrides a same-cycle clear
            end
        end
    end

endmodule

// ==== src/reorderBuffer.sv ====
`timescale 1ns/1ps
// Circular reorder buffer, tags 1..16, one dispatch and one commit per cycle.
// Dispatch while full is dropped; the dispatcher has to watch full.
// A ready head that is still speculative was mispredicted and flushes all entries.
module reorderBuffer import robPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   dispatchValid,
    input  opcodeT dispatchOp,
    input  regIdxT dispatchRd,
    input  logic   dispatchPred,
    input  dataT   dispatchTarget,
    input  tagT    cdbTag0,
    input  dataT   cdbData0,
    input  tagT    cdbTag1,
    input  dataT   cdbData1,
    input  logic   branchTaken,
    input  tagT    queryTagA,
    input  tagT    queryTagB,
    output tagT    allocTag,
    output logic   full,
    output dataT   queryDataA,
    output dataT   queryDataB,
    output logic   queryReadyA,
    output logic   queryReadyB,
    output logic   commitValid,
    output opcodeT commitOp,
    output regIdxT commitRd,
    output dataT   commitData,
    output tagT    commitTag,
    output ctrlT   commitCtrl,
    output logic   flush
);

    typedef logic [$clog2(robDepth)-1:0] slotT;
    typedef logic [$clog2(robDepth):0]   countT;

    opcodeT entryOp    [robDepth];
    regIdxT entryRd    [robDepth];
    dataT   entryData  [robDepth];  // branch target until a result lands
    logic   entryPred  [robDepth];
    logic   entryBusy  [robDepth];
    logic   entryReady [robDepth];
    logic   entrySpec  [robDepth];  // unresolved or mispredicted branch

    tagT   headTag;
    tagT   tailTag;
    countT occupancy;
    countT occupancyNext;

    slotT headSlot;
    slotT tailSlot;
    slotT cdbSlot0;
    slotT cdbSlot1;
    logic doAlloc;
    logic cdbHit0;
    logic cdbHit1;
    logic cdbBranch0;
    logic cdbBranch1;
    logic retire;
    logic mispredict;
    ctrlT headCtrl;

    // tag 16 maps to slot 15 through truncation
    function automatic slotT slotOf(tagT t);
        return slotT'(t - 1'b1);
    endfunction

    function automatic tagT nextTag(tagT t);
        return (t == tagT'(robDepth)) ? tagT'(1) : tagT'(t + 1'b1);
    endfunction

    assign headSlot = slotOf(headTag);
    assign tailSlot = slotOf(tailTag);
    assign allocTag = tailTag;
    assign doAlloc  = dispatchValid && !full;

    assign cdbSlot0   = slotOf(cdbTag0);
    assign cdbSlot1   = slotOf(cdbTag1);
    assign cdbHit0    = (cdbTag0 != '0) && entryBusy[cdbSlot0];  // stale tags ignored
    assign cdbHit1    = (cdbTag1 != '0) && entryBusy[cdbSlot1];
    assign cdbBranch0 = isCondBranch(entryOp[cdbSlot0]);
    assign cdbBranch1 = isCondBranch(entryOp[cdbSlot1]);

    assign retire     = entryBusy[headSlot] && entryReady[headSlot] && !entrySpec[headSlot];
    assign mispredict = entryBusy[headSlot] && entryReady[headSlot] && entrySpec[headSlot];

    assign occupancyNext = occupancy + countT'(doAlloc) - countT'(retire);

    always_comb begin
        headCtrl               = '0;
        headCtrl[ctrlRegWrite] = writesReg(entryOp[headSlot]);
        headCtrl[ctrlMemRead]  = (entryOp[headSlot] == opLw);
        headCtrl[ctrlMemWrite] = (entryOp[headSlot] == opSw);
    end

    // operand read ports, no check on busy
    assign queryDataA  = entryData[slotOf(queryTagA)];
    assign queryDataB  = entryData[slotOf(queryTagB)];
    assign queryReadyA = entryReady[slotOf(queryTagA)];
    assign queryReadyB = entryReady[slotOf(queryTagB)];

    // entry state, pointers and occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < robDepth; i++) begin
                entryBusy[i]  <= 1'b0;
                entryReady[i] <= 1'b0;
                entrySpec[i]  <= 1'b0;
            end
            headTag   <= tagT'(1);
            tailTag   <= tagT'(1);
            occupancy <= '0;
            full      <= 1'b0;
        end else begin
            if (doAlloc) begin
                entryBusy[tailSlot]  <= 1'b1;
                entryReady[tailSlot] <= readyAtDispatch(dispatchOp);
                entrySpec[tailSlot]  <= isCondBranch(dispatchOp);
                tailTag              <= nextTag(tailTag);
            end
            if (cdbHit0) begin
                entryReady[cdbSlot0] <= 1'b1;
                if (cdbBranch0 && (branchTaken == entryPred[cdbSlot0]))
                    entrySpec[cdbSlot0] <= 1'b0;  // prediction held
            end
            if (cdbHit1) begin
                entryReady[cdbSlot1] <= 1'b1;
                if (cdbBranch1 && (branchTaken == entryPred[cdbSlot1]))
                    entrySpec[cdbSlot1] <= 1'b0;
            end
            if (retire) begin
                entryBusy[headSlot] <= 1'b0;
                headTag             <= nextTag(headTag);
            end
            if (mispredict) begin
                // wipe everything, including a dispatch taken this cycle
                for (int i = 0; i < robDepth; i++)
                    entryBusy[i] <= 1'b0;
                headTag   <= tagT'(1);
                tailTag   <= tagT'(1);
                occupancy <= '0;
                full      <= 1'b1;  // blocks dispatch during the flush cycle
            end else begin
                occupancy <= occupancyNext;
                full      <= (occupancyNext == countT'(robDepth));
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (doAlloc) begin
            entryOp[tailSlot]   <= dispatchOp;
            entryRd[tailSlot]   <= dispatchRd;
            entryPred[tailSlot] <= dispatchPred;
            entryData[tailSlot] <= dispatchTarget;
        end
        if (cdbHit0 && !cdbBranch0)
            entryData[cdbSlot0] <= cdbData0;
        if (cdbHit1 && !cdbBranch1)
            entryData[cdbSlot1] <= cdbData1;  // port 1 wins a same-tag clash
    end

    // commit strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commitValid <= 1'b0;
            commitCtrl  <= '0;
            flush       <= 1'b0;
        end else begin
            commitValid <= retire;
            commitCtrl  <= retire ? headCtrl : ctrlT'(0);
            flush       <= mispredict;
        end
    end

    // commit payload, qualified by commitValid or flush
    always_ff @(posedge clk) begin
        if (retire || mispredict) begin
            commitOp   <= entryOp[headSlot];
            commitRd   <= entryRd[headSlot];
            commitData <= entryData[headSlot];  // target on a flush
            commitTag  <= headTag;
        end
    end

endmodule

// ==== src/robPkg.sv ====
// Shared widths, types and opcode classes for the ROB subsystem.
// Opcodes pack the op and funct fields of a classic RISC encoding into 12 bits.
// ROB tags run 1..robDepth and tag 0 means no pending writer.
package robPkg;

    localparam int robDepth = 16;
    localparam int numRegs  = 32;

    typedef logic [4:0]  tagT;     // 0 = none
    typedef logic [11:0] opcodeT;
    typedef logic [4:0]  regIdxT;
    typedef logic [31:0] dataT;
    typedef logic [2:0]  ctrlT;    // commit control bits

    // bit positions inside ctrlT
    localparam int ctrlRegWrite = 2;
    localparam int ctrlMemRead  = 1;
    localparam int ctrlMemWrite = 0;

    localparam opcodeT opAdd = 12'h020;
    localparam opcodeT opSub = 12'h022;
    localparam opcodeT opLw  = 12'h8C0;
    localparam opcodeT opSw  = 12'hAC0;
    localparam opcodeT opBeq = 12'h100;
    localparam opcodeT opBne = 12'h140;
    localparam opcodeT opJ   = 12'h080;
    localparam opcodeT opJal = 12'h0C0;
    localparam opcodeT opJr  = 12'h008;
    localparam opcodeT opHlt = 12'hFFF;

    // true for anything that leaves a result in rd
    function automatic logic writesReg(opcodeT op);
        logic noWrite;
        noWrite = (op == opJr)  || (op == opSw) || (op == opBeq) ||
                  (op == opBne) || (op == opJ)  || (op == opHlt);
        return !noWrite;
    endfunction

    // predicted branches, resolved on the result bus
    function automatic logic isCondBranch(opcodeT op);
        return (op == opBeq) || (op == opBne);
    endfunction

    // no execution unit ever reports these
    function automatic logic readyAtDispatch(opcodeT op);
        return (op == opJal) || (op == opHlt);
    endfunction

endpackage

// ==== src/robSubsystem.sv ====
`timescale 1ns/1ps
// Commit side of the core: reorder buffer plus register status table.
// Dispatch and result writes are one-cycle strobes without back-pressure.
module robSubsystem import robPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   dispatchValid,
    input  opcodeT dispatchOp,
    input  regIdxT dispatchRd,
    input  logic   dispatchPred,
    input  dataT   dispatchTarget,
    input  tagT    cdbTag0,
    input  dataT   cdbData0,
    input  tagT    cdbTag1,
    input  dataT   cdbData1,
    input  logic   branchTaken,
    input  regIdxT srcA,
    input  regIdxT srcB,
    output tagT    allocTag,
    output logic   full,
    output dataT   srcAValue,
    output dataT   srcBValue,
    output logic   srcAReady,
    output logic   srcBReady,
    output tagT    srcATag,
    output tagT    srcBTag,
    output logic   commitValid,
    output opcodeT commitOp,
    output regIdxT commitRd,
    output dataT   commitData,
    output tagT    commitTag,
    output ctrlT   commitCtrl,
    output logic   flush
);

    tagT  queryTagA;
    tagT  queryTagB;
    dataT queryDataA;
    dataT queryDataB;
    logic queryReadyA;
    logic queryReadyB;

    reorderBuffer u_rob (
        .clk            (clk),
        .rst            (rst),
        .dispatchValid  (dispatchValid),
        .dispatchOp     (dispatchOp),
        .dispatchRd     (dispatchRd),
        .dispatchPred   (dispatchPred),
        .dispatchTarget (dispatchTarget),
        .cdbTag0        (cdbTag0),
        .cdbData0       (cdbData0),
        .cdbTag1        (cdbTag1),
        .cdbData1       (cdbData1),
        .branchTaken    (branchTaken),
        .queryTagA      (queryTagA),
        .queryTagB      (queryTagB),
        .allocTag       (allocTag),
        .full           (full),
        .queryDataA     (queryDataA),
        .queryDataB     (queryDataB),
        .queryReadyA    (queryReadyA),
        .queryReadyB    (queryReadyB),
        .commitValid    (commitValid),
        .commitOp       (commitOp),
        .commitRd       (commitRd),
        .commitData     (commitData),
        .commitTag      (commitTag),
        .commitCtrl     (commitCtrl),
        .flush          (flush)
    );

    regStatusTable u_regStatus (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .dispatchOp    (dispatchOp),
        .dispatchRd    (dispatchRd),
        .allocTag      (allocTag),
        .srcA          (srcA),
        .srcB          (srcB),
        .queryDataA    (queryDataA),
        .queryDataB    (queryDataB),
        .queryReadyA   (queryReadyA),
        .queryReadyB   (queryReadyB),
        .commitValid   (commitValid),
        .commitCtrl    (commitCtrl),
        .commitRd      (commitRd),
        .commitData    (commitData),
        .commitTag     (commitTag),
        .flush         (flush),
        .queryTagA     (queryTagA),
        .queryTagB     (queryTagB),
        .srcAValue     (srcAValue),
        .srcBValue     (srcBValue),
        .srcAReady     (srcAReady),
        .srcBReady     (srcBReady),
        .srcATag       (srcATag),
        .srcBTag       (srcBTag)
    );

endmodule

// ==== tb/reorderBuffer_asserts.sv ====
`timescale 1ns/1ps
// Invariants of the reorder buffer, bound into every reorderBuffer instance.
// Sampled on the rising edge, ignored while reset is high.
module robInvariants import robPkg::*; (
    input logic clk,
    input logic rst,
    input logic commitValid,
    input logic flush,
    input logic full,
    input tagT  headTag,
    input tagT  tailTag
);

    int failCount = 0;

    // a flush cycle carries no commit
    commitFlushExclusive: assert property (
        @(posedge clk) disable iff (rst) !(commitValid && flush)
    ) else begin
        failCount++;
        $error("commitValid and flush are high together");
    end

    // full means the tail caught up with the head
    fullAtWrap: assert property (
        @(posedge clk) disable iff (rst) full |-> (headTag == tailTag)
    ) else begin
        failCount++;
        $error("full is set while head %0d and tail %0d differ", headTag, tailTag);
    end

    flushResetsHead: assert property (
        @(posedge clk) disable iff (rst) flush |-> (headTag == tagT'(1))
    ) else begin
        failCount++;
        $error("head tag is %0d during flush, expected 1", headTag);
    end

endmodule

bind reorderBuffer robInvariants u_invariants (
    .clk         (clk),
    .rst         (rst),
    .commitValid (commitValid),
    .flush       (flush),
    .full        (full),
    .headTag     (headTag),
    .tailTag     (tailTag)
);

// ==== tb/tbRobSubsystem.sv ====
`timescale 1ns/1ps
// Directed tests for the ROB subsystem. Inputs change right after the rising edge.
// Commits are collected at the rising edge and compared in order; flush is polled.
module tbRobSubsystem import robPkg::*; ();

    localparam int clkPeriod   = 40;
    localparam int resetCycles = 10;
    localparam int waitLimit   = 40;     // cycles per commit or flush wait
    // rough cycle budget per test
    localparam int inOrderCycles   = 25;
    localparam int lookupCycles    = 15;
    localparam int branchCycles    = 15;
    localparam int mispredCycles   = 30;
    localparam int fullCycles      = 75;
    localparam int opClassCycles   = 30;
    localparam int marginCycles    = 100;
    localparam int watchdogCycles  = resetCycles + inOrderCycles + lookupCycles + branchCycles
                                   + mispredCycles + fullCycles + opClassCycles + marginCycles;

    localparam ctrlT ctrlNone  = 3'b000;
    localparam ctrlT ctrlAlu   = 3'b100;  // regWrite
    localparam ctrlT ctrlLoad  = 3'b110;  // regWrite and memRead
    localparam ctrlT ctrlStore = 3'b001;  // memWrite only

    logic   clk;
    logic   rst;
    logic   dispatchValid;
    opcodeT dispatchOp;
    regIdxT dispatchRd;
    logic   dispatchPred;
    dataT   dispatchTarget;
    tagT    cdbTag0;
    dataT   cdbData0;
    tagT    cdbTag1;
    dataT   cdbData1;
    logic   branchTaken;
    regIdxT srcA;
    regIdxT srcB;
    tagT    allocTag;
    logic   full;
    dataT   srcAValue;
    dataT   srcBValue;
    logic   srcAReady;
    logic   srcBReady;
    tagT    srcATag;
    tagT    srcBTag;
    logic   commitValid;
    opcodeT commitOp;
    regIdxT commitRd;
    dataT   commitData;
    tagT    commitTag;
    ctrlT   commitCtrl;
    logic   flush;

    tagT    commitTagQ  [$];
    regIdxT commitRdQ   [$];
    dataT   commitDataQ [$];
    ctrlT   commitCtrlQ [$];
    opcodeT commitOpQ   [$];
    int     flushCount  = 0;
    int     checkCount  = 0;
    int     errorCount  = 0;
    int     assertFails = 0;
    tagT    expTail     = 5'd1;  // model of the tail pointer
    int unsigned seedValue;

    robSubsystem u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // records every commit strobe of the previous cycle
    always @(posedge clk) begin
        if (!rst) begin
            if (commitValid) begin
                commitTagQ.push_back(commitTag);
                commitRdQ.push_back(commitRd);
                commitDataQ.push_back(commitData);
                commitCtrlQ.push_back(commitCtrl);
                commitOpQ.push_back(commitOp);
            end
            if (flush)
                flushCount++;
        end
    end

    function automatic tagT advanceTag(tagT t);
        return (t == tagT'(robDepth)) ? tagT'(1) : tagT'(t + 1);  // 16 wraps to 1
    endfunction

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic dispatchOne(opcodeT op, regIdxT rd, logic pred, dataT target,
                               output tagT tag);
        @(negedge clk);
        checkValue("full", full, 1'b0);
        checkValue("allocTag", allocTag, expTail);
        tag     = expTail;
        expTail = advanceTag(expTail);
        @(posedge clk);
        dispatchValid  <= 1'b1;
        dispatchOp     <= op;
        dispatchRd     <= rd;
        dispatchPred   <= pred;
        dispatchTarget <= target;
        @(posedge clk);
        dispatchValid <= 1'b0;  // entry taken at this edge
    endtask

    task automatic driveResult(tagT tag0, dataT data0, tagT tag1, dataT data1, logic taken);
        @(posedge clk);
        cdbTag0     <= tag0;
        cdbData0    <= data0;
        cdbTag1     <= tag1;
        cdbData1    <= data1;
        branchTaken <= taken;
        @(posedge clk);
        cdbTag0     <= '0;
        cdbTag1     <= '0;
        branchTaken <= 1'b0;
    endtask

    task automatic waitCommits(int count);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (commitTagQ.size() < count && waited < waitLimit);
        if (commitTagQ.size() < count) begin
            errorCount++;
            $display("ERROR: only %0d of %0d commits arrived in time", commitTagQ.size(), count);
        end
    endtask

    task automatic waitFlush();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!flush && waited < waitLimit);
        if (!flush) begin
            errorCount++;
            $display("ERROR: flush did not arrive within %0d cycles", waitLimit);
        end
    endtask

    task automatic checkCommit(int idx, tagT tag, regIdxT rd, ctrlT ctrl, dataT data,
                               logic withData);
        if (idx >= commitTagQ.size()) begin
            errorCount++;
            $display("ERROR: commit number %0d never happened", idx);
        end else begin
            checkValue("commitTag", commitTagQ[idx], tag);
            checkValue("commitRd", commitRdQ[idx], rd);
            checkValue("commitCtrl", commitCtrlQ[idx], ctrl);
            if (withData)
                checkValue("commitData", commitDataQ[idx], data);
        end
    endtask

    task automatic testInOrderCommit();
        tagT  t1;
        tagT  t2;
        tagT  t3;
        dataT d1;
        dataT d2;
        dataT d3;
        int   base;
        base = commitTagQ.size();
        d1   = $urandom();
        d2   = $urandom();
        d3   = $urandom();
        dispatchOne(opAdd, 5'd1, 1'b0, '0, t1);
        dispatchOne(opAdd, 5'd2, 1'b0, '0, t2);
        dispatchOne(opAdd, 5'd3, 1'b0, '0, t3);
        driveResult(t3, d3, t2, d2, 1'b0);  // youngest first
        driveResult(t1, d1, '0, '0, 1'b0);
        waitCommits(base + 3);
        checkCommit(base, t1, 5'd1, ctrlAlu, d1, 1'b1);
        checkCommit(base + 1, t2, 5'd2, ctrlAlu, d2, 1'b1);
        checkCommit(base + 2, t3, 5'd3, ctrlAlu, d3, 1'b1);
    endtask

    task automatic testOperandLookup();
        tagT  t;
        dataT d;
        int   base;
        base = commitTagQ.size();
        d    = $urandom();
        @(posedge clk);
        srcA <= 5'd5;
        srcB <= 5'd0;
        dispatchOne(opSub, 5'd5, 1'b0, '0, t);
        @(negedge clk);
        checkValue("srcAReady", srcAReady, 1'b0);
        checkValue("srcATag", srcATag, t);
        checkValue("srcBValue", srcBValue, '0);  // r0 never renamed
        checkValue("srcBReady", srcBReady, 1'b1);
        driveResult(t, d, '0, '0, 1'b0);
        @(negedge clk);
        checkValue("srcAReady", srcAReady, 1'b1);
        checkValue("srcAValue", srcAValue, d);
        checkValue("srcATag", srcATag, t);
        waitCommits(base + 1);
        checkCommit(base, t, 5'd5, ctrlAlu, d, 1'b1);
        checkValue("srcAValue", srcAValue, d);  // now from the register file
        checkValue("srcATag", srcATag, '0);
        checkValue("srcAReady", srcAReady, 1'b1);
    endtask

    task automatic testCorrectBranch();
        tagT  t;
        int   base;
        int   flushesBefore;
        base          = commitTagQ.size();
        flushesBefore = flushCount;
        dispatchOne(opBeq, 5'd0, 1'b1, $urandom(), t);
        driveResult(t, '0, '0, '0, 1'b1);
        waitCommits(base + 1);
        @(negedge clk);
        checkCommit(base, t, 5'd0, ctrlNone, '0, 1'b0);
        if (commitOpQ.size() > base)
            checkValue("commitOp", commitOpQ[base], opBeq);
        checkValue("flushCount", flushCount, flushesBefore);
    endtask

    task automatic testMispredict();
        tagT  branchTag;
        tagT  youngA;
        tagT  youngB;
        dataT target;
        dataT youngDataA;
        dataT youngDataB;
        int   base;
        target     = $urandom();
        youngDataA = $urandom();
        youngDataB = $urandom();
        @(posedge clk);
        srcA <= 5'd8;
        srcB <= 5'd9;
        base = commitTagQ.size();
        dispatchOne(opBne, 5'd0, 1'b0, target, branchTag);
        dispatchOne(opAdd, 5'd8, 1'b0, '0, youngA);
        dispatchOne(opAdd, 5'd9, 1'b0, '0, youngB);
        @(negedge clk);
        checkValue("srcBReady", srcBReady, 1'b0);
        driveResult(youngA, youngDataA, youngB, youngDataB, 1'b0);
        @(negedge clk);
        checkValue("srcATag", srcATag, youngA);
        checkValue("srcBTag", srcBTag, youngB);
        checkValue("srcAValue", srcAValue, youngDataA);
        checkValue("srcBReady", srcBReady, 1'b1);
        checkValue("srcBValue", srcBValue, youngDataB);
        driveResult(branchTag, '0, '0, '0, 1'b1);  // predicted not taken, was taken
        waitFlush();
        checkValue("commitData", commitData, target);
        checkValue("commitOp", commitOp, opBne);
        checkValue("full", full, 1'b1);
        @(negedge clk);
        checkValue("full", full, 1'b0);
        checkValue("srcAReady", srcAReady, 1'b1);
        checkValue("srcATag", srcATag, '0);
        checkValue("srcAValue", srcAValue, '0);
        checkValue("srcBReady", srcBReady, 1'b1);
        checkValue("srcBTag", srcBTag, '0);
        checkValue("srcBValue", srcBValue, '0);
        repeat (4) @(negedge clk);
        if (commitTagQ.size() != base) begin
            errorCount++;
            $display("ERROR: entries behind the mispredicted branch were committed");
        end
        expTail = tagT'(1);  // flush restarts the pointers
    endtask

    task automatic testFullRefill();
        tagT  tags   [robDepth];
        dataT values [robDepth];
        int   base;
        base = commitTagQ.size();
        for (int i = 0; i < robDepth; i++) begin
            values[i] = $urandom();
            dispatchOne(opAdd, regIdxT'(10 + i), 1'b0, '0, tags[i]);
        end
        @(negedge clk);
        checkValue("full", full, 1'b1);
        driveResult(tags[0], values[0], '0, '0, 1'b0);
        waitCommits(base + 1);
        checkValue("full", full, 1'b0);
        checkValue("allocTag", allocTag, tags[0]);  // freed slot comes next
        for (int i = 1; i < robDepth; i += 2) begin
            if (i + 1 < robDepth)
                driveResult(tags[i], values[i], tags[i + 1], values[i + 1], 1'b0);
            else
                driveResult(tags[i], values[i], '0, '0, 1'b0);
        end
        waitCommits(base + robDepth);
        for (int i = 0; i < robDepth; i++)
            checkCommit(base + i, tags[i], regIdxT'(10 + i), ctrlAlu, values[i], 1'b1);
    endtask

    task automatic testOpcodeClasses();
        tagT  jalTag;
        tagT  hltTag;
        tagT  swTag;
        tagT  lwTag;
        dataT storeData;
        dataT loadData;
        int   base;
        storeData = $urandom();
        loadData  = $urandom();
        @(posedge clk);
        srcA <= 5'd4;
        base = commitTagQ.size();
        dispatchOne(opJal, 5'd31, 1'b0, $urandom(), jalTag);
        dispatchOne(opHlt, 5'd0, 1'b0, '0, hltTag);
        waitCommits(base + 2);  // no results needed
        checkCommit(base, jalTag, 5'd31, ctrlAlu, '0, 1'b0);
        checkCommit(base + 1, hltTag, 5'd0, ctrlNone, '0, 1'b0);
        dispatchOne(opSw, 5'd0, 1'b0, '0, swTag);
        dispatchOne(opLw, 5'd4, 1'b0, '0, lwTag);
        driveResult(swTag, storeData, lwTag, loadData, 1'b0);
        waitCommits(base + 4);
        checkCommit(base + 2, swTag, 5'd0, ctrlStore, storeData, 1'b1);
        checkCommit(base + 3, lwTag, 5'd4, ctrlLoad, loadData, 1'b1);
        checkValue("srcAValue", srcAValue, loadData);
        checkValue("srcATag", srcATag, '0);
    endtask

    initial begin
        seedValue      = $urandom(32'h5244);
        rst            = 1'b1;
        dispatchValid  = 1'b0;
        dispatchOp     = opAdd;
        dispatchRd     = '0;
        dispatchPred   = 1'b0;
        dispatchTarget = '0;
        cdbTag0        = '0;
        cdbData0       = '0;
        cdbTag1        = '0;
        cdbData1       = '0;
        branchTaken    = 1'b0;
        srcA           = '0;
        srcB           = '0;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("full", full, 1'b0);
        checkValue("commitValid", commitValid, 1'b0);
        checkValue("flush", flush, 1'b0);
        checkValue("commitCtrl", commitCtrl, ctrlNone);
        checkValue("allocTag", allocTag, 5'd1);
        testInOrderCommit();
        testOperandLookup();
        testCorrectBranch();
        testMispredict();
        testFullRefill();
        testOpcodeClasses();
        repeat (2) @(negedge clk);
        assertFails = u_dut.u_rob.u_invariants.failCount;
        errorCount += assertFails;
        $display("tbRobSubsystem: %0d checks, %0d assertion failures, %0d errors",
                 checkCount, assertFails, errorCount);
        if (errorCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("ERROR: watchdog expired after %0d cycles, tests did not finish", watchdogCycles);
        $display("Checks failed");
        $finish;
    end

endmodule
